/* hw/cpu_isa_pkg.sv */
`default_nettype none

package cpu_isa_pkg;

  ///////////////////////////////////////////////////
  // Widths
  ///////////////////////////////////////////////////

  localparam int DATA_W     = 8;   // Registers, data pins and instruction words
  localparam int PC_W       = 4;
  localparam int PROG_DEPTH = 16;  // One word per program counter value
  localparam int OPCODE_W   = 4;   // High nibble of an instruction
  localparam int OPERAND_W  = 4;   // Low nibble of an instruction

  ///////////////////////////////////////////////////
  // Opcodes
  ///////////////////////////////////////////////////

  localparam logic [OPCODE_W-1:0] OP_NOP    = 4'd0;
  localparam logic [OPCODE_W-1:0] OP_LDA_LO = 4'd1;
  localparam logic [OPCODE_W-1:0] OP_LDA_HI = 4'd2;
  localparam logic [OPCODE_W-1:0] OP_LDB_LO = 4'd3;
  localparam logic [OPCODE_W-1:0] OP_LDB_HI = 4'd4;
  localparam logic [OPCODE_W-1:0] OP_LDC_LO = 4'd5;
  localparam logic [OPCODE_W-1:0] OP_LDC_HI = 4'd6;
  localparam logic [OPCODE_W-1:0] OP_ADD    = 4'd7;  // C = A + B
  localparam logic [OPCODE_W-1:0] OP_SUB    = 4'd8;  // C = A - B
  localparam logic [OPCODE_W-1:0] OP_MUL    = 4'd9;  // C = A * B, low byte
  localparam logic [OPCODE_W-1:0] OP_OUT    = 4'd10;
  localparam logic [OPCODE_W-1:0] OP_IN     = 4'd11;

  // Register selects for IN and OUT
  localparam logic [OPERAND_W-1:0] SEL_A = 4'd0;
  localparam logic [OPERAND_W-1:0] SEL_B = 4'd1;
  localparam logic [OPERAND_W-1:0] SEL_C = 4'd2;

  // Loads carry a data nibble in the low half
  typedef struct packed {
    logic [OPCODE_W-1:0]  opcode;
    logic [OPERAND_W-1:0] imm;
  } instr_imm_t;

  // IN and OUT carry a register select in the low half
  typedef struct packed {
    logic [OPCODE_W-1:0]  opcode;
    logic [OPERAND_W-1:0] reg_sel;
  } instr_reg_t;

  typedef union packed {
    instr_imm_t imm_view;
    instr_reg_t reg_view;
  } instr_t;

endpackage

`default_nettype wire

/* hw/cpu_io_pkg.sv */
`default_nettype none

package cpu_io_pkg;

  ///////////////////////////////////////////////////
  // Control field on uio_in
  ///////////////////////////////////////////////////

  localparam int RUN_BIT = 7;  // High while the CPU executes

  // Mode field
  localparam int MODE_HI = 5;
  localparam int MODE_LO = 4;

  localparam logic [MODE_HI-MODE_LO:0] MODE_WRITE = 2'b01;  // Store ui_in into the program

  // Program address used by MODE_WRITE
  localparam int ADDR_HI = 3;
  localparam int ADDR_LO = 0;

endpackage

`default_nettype wire

/* hw/program_memory.sv */
`default_nettype none

module program_memory
  import cpu_isa_pkg::*;
  import cpu_io_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [DATA_W-1:0] ui_in,
  input  logic [DATA_W-1:0] uio_in,
  input  logic [PC_W-1:0]   pc,
  output instr_t            instr
);

  logic [DATA_W-1:0] mem [PROG_DEPTH];

  logic              run;
  logic              wr_en;
  logic [PC_W-1:0]   wr_addr;

  ///////////////////////////////////////////////////
  // Write port from the pins
  ///////////////////////////////////////////////////

  assign run     = uio_in[RUN_BIT];
  assign wr_addr = uio_in[ADDR_HI:ADDR_LO];

  // Loading only happens while stopped
  assign wr_en = !run && (uio_in[MODE_HI:MODE_LO] == MODE_WRITE);

  // Cleared program is all NOP
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem <= '{default: '0};
    end else if (wr_en) begin
      mem[wr_addr] <= ui_in;
    end
  end

  ///////////////////////////////////////////////////
  // Read port to the core
  ///////////////////////////////////////////////////

  assign instr = instr_t'(mem[pc]);  // Same cycle as pc

  // A running edge must leave the addressed word as it was
  a_no_write_while_run : assert property (
    @(posedge clk) disable iff (!rst_n)
    run |=> mem[$past(wr_addr)] == $past(mem[wr_addr])
  );

endmodule

`default_nettype wire

/* hw/cpu_core.sv */
`default_nettype none

module cpu_core
  import cpu_isa_pkg::*;
  import cpu_io_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [DATA_W-1:0]    uio_in,
  input  logic [DATA_W-1:0]    ui_in,
  input  instr_t               instr,
  output logic [PC_W-1:0]      pc,
  output logic [DATA_W-1:0]    reg_a,
  output logic [DATA_W-1:0]    reg_b,
  output logic [DATA_W-1:0]    reg_c,
  output logic                 out_strobe,
  output logic [OPERAND_W-1:0] out_sel
);

  logic                 run;
  logic [OPCODE_W-1:0]  opcode;
  logic [OPERAND_W-1:0] imm;
  logic [OPERAND_W-1:0] reg_sel;
  logic                 out_valid;

  logic [DATA_W-1:0]    alu_sum;
  logic [DATA_W-1:0]    alu_diff;
  logic [DATA_W-1:0]    alu_prod;

  assign run = uio_in[RUN_BIT];

  ///////////////////////////////////////////////////
  // Decode
  ///////////////////////////////////////////////////

  assign opcode  = instr.imm_view.opcode;
  assign imm     = instr.imm_view.imm;      // Loads
  assign reg_sel = instr.reg_view.reg_sel;  // IN and OUT

  // Selects above C are ignored
  assign out_valid = (opcode == OP_OUT) && (reg_sel <= SEL_C);

  // ALU results wrap at 8 bits
  assign alu_sum  = reg_a + reg_b;
  assign alu_diff = reg_a - reg_b;
  assign alu_prod = reg_a * reg_b;  // Low byte of the product

  ///////////////////////////////////////////////////
  // Program counter and registers
  ///////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc         <= '0;
      reg_a      <= '0;
      reg_b      <= '0;
      reg_c      <= '0;
      out_strobe <= 1'b0;
    end else begin
      out_strobe <= 1'b0;  // One cycle per OUT
      if (run) begin
        pc <= pc + 1'b1;  // Wraps from 15 to 0
        case (opcode)
          OP_NOP:    ;
          OP_LDA_LO: reg_a[OPERAND_W-1:0]      <= imm;
          OP_LDA_HI: reg_a[DATA_W-1:OPERAND_W] <= imm;
          OP_LDB_LO: reg_b[OPERAND_W-1:0]      <= imm;
          OP_LDB_HI: reg_b[DATA_W-1:OPERAND_W] <= imm;
          OP_LDC_LO: reg_c[OPERAND_W-1:0]      <= imm;
          OP_LDC_HI: reg_c[DATA_W-1:OPERAND_W] <= imm;
          OP_ADD:    reg_c <= alu_sum;
          OP_SUB:    reg_c <= alu_diff;
          OP_MUL:    reg_c <= alu_prod;
          OP_OUT:    out_strobe <= out_valid;
          OP_IN: begin
            case (reg_sel)
              SEL_A:   reg_a <= ui_in;
              SEL_B:   reg_b <= ui_in;
              SEL_C:   reg_c <= ui_in;
              default: ;
            endcase
          end
          default: ;  // Opcodes 12 to 15 do nothing
        endcase
      end
    end
  end

  // Select travels with the strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_sel <= '0;
    end else if (run && out_valid) begin
      out_sel <= reg_sel;
    end
  end

  ///////////////////////////////////////////////////
  // Checks
  ///////////////////////////////////////////////////

  a_pc_hold_when_stopped : assert property (
    @(posedge clk) disable iff (!rst_n)
    !run |=> $stable(pc)
  );

  // Back to back strobes need a new instruction
  a_strobe_single_cycle : assert property (
    @(posedge clk) disable iff (!rst_n)
    out_strobe |=> !out_strobe || (pc != $past(pc))
  );

endmodule

`default_nettype wire

/* hw/output_port.sv */
`default_nettype none

module output_port
  import cpu_isa_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [DATA_W-1:0]    reg_a,
  input  logic [DATA_W-1:0]    reg_b,
  input  logic [DATA_W-1:0]    reg_c,
  input  logic                 out_strobe,
  input  logic [OPERAND_W-1:0] out_sel,
  output logic [DATA_W-1:0]    uo_out
);

  logic [DATA_W-1:0] out_mux;

  always_comb begin
    case (out_sel)
      SEL_A:   out_mux = reg_a;
      SEL_B:   out_mux = reg_b;
      SEL_C:   out_mux = reg_c;
      default: out_mux = '0;
    endcase
  end

  // Pins hold the last OUT value
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      uo_out <= '0;
    end else if (out_strobe) begin
      uo_out <= out_mux;
    end
  end

  // Core only strobes for A, B or C
  a_strobe_sel_valid : assert property (
    @(posedge clk) disable iff (!rst_n)
    out_strobe |-> out_sel <= SEL_C
  );

endmodule

`default_nettype wire

/* hw/cpu_top.sv */
`default_nettype none

module cpu_top
  import cpu_isa_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic [DATA_W-1:0] ui_in,
  input  logic [DATA_W-1:0] uio_in,
  output logic [DATA_W-1:0] uo_out
);

  logic [PC_W-1:0]      pc;
  instr_t               instr;
  logic [DATA_W-1:0]    reg_a;
  logic [DATA_W-1:0]    reg_b;
  logic [DATA_W-1:0]    reg_c;
  logic                 out_strobe;
  logic [OPERAND_W-1:0] out_sel;

  ///////////////////////////////////////////////////
  // Program store, core and output register
  ///////////////////////////////////////////////////

  program_memory program_memory_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .ui_in  (ui_in),
    .uio_in (uio_in),
    .pc     (pc),
    .instr  (instr)
  );

  cpu_core cpu_core_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .uio_in     (uio_in),      // Run bit
    .ui_in      (ui_in),       // IN data
    .instr      (instr),
    .pc         (pc),
    .reg_a      (reg_a),
    .reg_b      (reg_b),
    .reg_c      (reg_c),
    .out_strobe (out_strobe),
    .out_sel    (out_sel)
  );

  output_port output_port_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .reg_a      (reg_a),
    .reg_b      (reg_b),
    .reg_c      (reg_c),
    .out_strobe (out_strobe),
    .out_sel    (out_sel),
    .uo_out     (uo_out)
  );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Two full cycles in reset, released on a falling edge
  initial begin
    rst_n = 1'b0;
    #(2 * PERIOD_NS);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* testbench/tb_cpu_top.sv */
`default_nettype none

module tb_cpu_top
  import cpu_isa_pkg::*;
  import cpu_io_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          CLK_PERIOD  = 20;
  localparam logic [31:0] LFSR_SEED   = 32'h7f57_722f;
  localparam int          NUM_TESTS   = 5;
  localparam int          TEST_CYCLES = 60;  // Budget per test
  localparam int          SAMPLE_LEN  = 32;

  logic              clk;
  logic              rst_n;
  logic [DATA_W-1:0] ui_in;
  logic [DATA_W-1:0] uio_in;
  logic [DATA_W-1:0] uo_out;

  logic [31:0]       lfsr;
  logic [DATA_W-1:0] run_ctrl;
  logic [DATA_W-1:0] prog [PROG_DEPTH];
  logic [DATA_W-1:0] ui_seq [SAMPLE_LEN + 1];  // ui_in seen by each executing edge
  logic [DATA_W-1:0] samples [SAMPLE_LEN];     // uo_out after each executing edge
  int                err_count;
  int                test_err_start;
  int                tests_passed;
  int                tests_failed;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) tb_clock_gen_inst (
    .clk   (clk),
    .rst_n (rst_n)
  );

  cpu_top cpu_top_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .ui_in  (ui_in),
    .uio_in (uio_in),
    .uo_out (uo_out)
  );

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic next_random_byte(output logic [DATA_W-1:0] value);
    value = '0;
    for (int i = 0; i < DATA_W; i++) begin
      lfsr  = lfsr_next(lfsr);
      value = {value[DATA_W-2:0], lfsr[0]};
    end
  endtask

  function automatic logic [DATA_W-1:0] encode(input logic [3:0] opcode, input logic [3:0] low);
    return {opcode, low};
  endfunction

  function automatic logic [DATA_W-1:0] ctrl_word(input logic run, input logic [1:0] mode,
                                                  input logic [3:0] addr);
    logic [DATA_W-1:0] w;
    w = '0;
    w[RUN_BIT]          = run;
    w[MODE_HI:MODE_LO]  = mode;
    w[ADDR_HI:ADDR_LO]  = addr;
    return w;
  endfunction

  task automatic check(input string what, input logic [DATA_W-1:0] expected,
                       input logic [DATA_W-1:0] actual);
    if (actual !== expected) begin
      $display("ERROR at %0d ns: %s expected 0x%02h, got 0x%02h", $time, what, expected,
               actual);
      err_count++;
    end
  endtask

  task automatic finish_test(input string name);
    if (err_count == test_err_start) begin
      tests_passed++;
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d mismatches", name, err_count - test_err_start);
    end
    test_err_start = err_count;
  endtask

  // Empty program, noise on ui_in
  task automatic prepare_test();
    for (int i = 0; i < PROG_DEPTH; i++) begin
      prog[i] = encode(OP_NOP, 4'h0);
    end
    for (int i = 0; i <= SAMPLE_LEN; i++) begin
      next_random_byte(ui_seq[i]);
    end
  endtask

  task automatic load_program();
    for (int a = 0; a < PROG_DEPTH; a++) begin
      @(posedge clk);
      uio_in <= ctrl_word(1'b0, MODE_WRITE, 4'(a));
      ui_in  <= prog[a];
    end
    @(posedge clk);
    uio_in <= '0;
  endtask

  // Exactly n executing edges, then stopped again
  task automatic run_cycles(input int n, input logic [DATA_W-1:0] ctrl);
    @(posedge clk);
    uio_in <= ctrl;
    ui_in  <= ui_seq[0];
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      uio_in <= (i == n - 1) ? '0 : ctrl;
      ui_in  <= ui_seq[i + 1];
      @(negedge clk);
      samples[i] = uo_out;
    end
  endtask

  task automatic idle_check(input int n, input logic [DATA_W-1:0] expected);
    logic [DATA_W-1:0] noise;
    for (int i = 0; i < n; i++) begin
      next_random_byte(noise);
      @(posedge clk);
      ui_in <= noise;
      @(negedge clk);
      check("uo_out while stopped", expected, uo_out);
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset_idle();
    prepare_test();
    @(negedge clk);
    check("uo_out after reset", 8'h00, uo_out);
    run_cycles(20, run_ctrl);
    for (int i = 0; i < 20; i++) begin
      check("uo_out with empty program", 8'h00, samples[i]);
    end
    run_cycles(12, run_ctrl);  // pc back at 0
    finish_test("reset_idle");
  endtask

  // OUT at address k shows in samples[k+1]
  task automatic test_nibble_loads();
    prepare_test();
    prog[0] = encode(OP_LDA_LO, 4'hA);
    prog[1] = encode(OP_LDA_HI, 4'h5);
    prog[2] = encode(OP_LDB_LO, 4'h3);
    prog[3] = encode(OP_LDB_HI, 4'hC);
    prog[4] = encode(OP_LDC_LO, 4'hE);
    prog[5] = encode(OP_LDC_HI, 4'h7);
    prog[6] = encode(OP_OUT, SEL_A);
    prog[7] = encode(OP_OUT, SEL_B);
    prog[8] = encode(OP_OUT, SEL_C);
    load_program();
    run_cycles(PROG_DEPTH, run_ctrl);
    check("OUT A after nibble loads", 8'h5A, samples[7]);
    check("OUT B after nibble loads", 8'hC3, samples[8]);
    check("OUT C after nibble loads", 8'h7E, samples[9]);
    finish_test("nibble_loads");
  endtask

  task automatic test_alu();
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    prepare_test();
    next_random_byte(a);
    next_random_byte(b);
    prog[0] = encode(OP_LDA_LO, a[3:0]);
    prog[1] = encode(OP_LDA_HI, a[7:4]);
    prog[2] = encode(OP_LDB_LO, b[3:0]);
    prog[3] = encode(OP_LDB_HI, b[7:4]);
    prog[4] = encode(OP_ADD, 4'h0);
    prog[5] = encode(OP_OUT, SEL_C);
    prog[6] = encode(OP_SUB, 4'h0);
    prog[7] = encode(OP_OUT, SEL_C);
    prog[8] = encode(OP_MUL, 4'h0);
    prog[9] = encode(OP_OUT, SEL_C);
    load_program();
    run_cycles(PROG_DEPTH, run_ctrl);
    check("ADD result", 8'(a + b), samples[6]);
    check("SUB result", 8'(a - b), samples[8]);
    check("MUL result", 8'(a * b), samples[10]);  // Low byte of the product
    finish_test("alu");
  endtask

  task automatic test_in_loads();
    prepare_test();
    prog[0] = encode(OP_IN, SEL_A);
    prog[1] = encode(OP_IN, SEL_B);
    prog[2] = encode(OP_IN, SEL_C);
    prog[3] = encode(OP_OUT, SEL_A);
    prog[4] = encode(OP_OUT, SEL_B);
    prog[5] = encode(OP_OUT, SEL_C);
    prog[6] = encode(OP_IN, 4'h3);   // No such register
    prog[7] = encode(OP_OUT, 4'h3);
    prog[8] = encode(OP_OUT, SEL_A);
    load_program();
    run_cycles(PROG_DEPTH, run_ctrl);
    check("IN A", ui_seq[0], samples[4]);
    check("IN B", ui_seq[1], samples[5]);
    check("IN C", ui_seq[2], samples[6]);
    check("OUT with select 3", ui_seq[2], samples[8]);
    check("A after IN with select 3", ui_seq[0], samples[9]);
    finish_test("in_loads");
  endtask

  task automatic test_control();
    prepare_test();
    prog[0]  = encode(OP_LDA_LO, 4'hC);
    prog[1]  = encode(OP_LDA_HI, 4'h3);
    prog[2]  = encode(OP_LDB_LO, 4'h6);
    prog[3]  = encode(OP_LDB_HI, 4'h9);
    prog[4]  = encode(OP_OUT, SEL_A);
    prog[5]  = encode(4'hC, 4'h5);    // Unused opcodes
    prog[6]  = encode(4'hD, 4'h2);
    prog[7]  = encode(4'hE, 4'h9);
    prog[8]  = encode(4'hF, 4'h1);
    prog[10] = encode(OP_OUT, SEL_B);
    prog[12] = encode(OP_OUT, SEL_A);
    load_program();
    run_cycles(6, run_ctrl);
    check("OUT A before stop", 8'h3C, samples[5]);
    idle_check(10, 8'h3C);
    // Resumes at address 6
    run_cycles(10, run_ctrl);
    for (int i = 0; i < 5; i++) begin
      check("uo_out through unused opcodes", 8'h3C, samples[i]);
    end
    check("OUT B after unused opcodes", 8'h96, samples[5]);
    check("OUT A after unused opcodes", 8'h3C, samples[7]);
    // Try to overwrite the OUT A at address 4 while running
    for (int i = 0; i <= SAMPLE_LEN; i++) begin
      ui_seq[i] = encode(OP_OUT, SEL_B);
    end
    run_cycles(PROG_DEPTH, ctrl_word(1'b1, MODE_WRITE, 4'h4));
    check("OUT A during write attempt", 8'h3C, samples[5]);
    run_cycles(PROG_DEPTH, run_ctrl);
    check("OUT A after wrap", 8'h3C, samples[5]);
    check("OUT B after wrap", 8'h96, samples[11]);
    finish_test("control");
  endtask

  //////////////////////////////////////////////////
  // Sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    ui_in          = '0;
    uio_in         = '0;
    lfsr           = LFSR_SEED;
    run_ctrl       = ctrl_word(1'b1, 2'b00, 4'h0);
    err_count      = 0;
    test_err_start = 0;
    tests_passed   = 0;
    tests_failed   = 0;
    @(posedge rst_n);
    test_reset_idle();
    test_nibble_loads();
    test_alu();
    test_in_loads();
    test_control();
    $display("Tests passed: %0d, failed: %0d, mismatches: %0d", tests_passed, tests_failed,
             err_count);
    if (tests_failed == 0 && err_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d ns",
             NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
hw/cpu_isa_pkg.sv
hw/cpu_io_pkg.sv
hw/program_memory.sv
hw/cpu_core.sv
hw/output_port.sv
hw/cpu_top.sv
testbench/tb_clock_gen.sv
testbench/tb_cpu_top.sv

/* Bender.yml */
package:
  name: accu_cpu

sources:
  - files:
      - hw/cpu_isa_pkg.sv
      - hw/cpu_io_pkg.sv
      - hw/program_memory.sv
      - hw/cpu_core.sv
      - hw/output_port.sv
      - hw/cpu_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_cpu_top.sv
